// ==== cdrx_top.f ====
source/cdrx_pkg.sv
source/cdrx_if.sv
source/cdrx_sdpram.sv
source/cdrx_frame_ram.sv
source/cdrx_frame_writer.sv
source/cdrx_host_reader.sv
source/cdrx_ctrl_regs.sv
source/cdrx_top.sv
verification/cdrx_tb.sv

// ==== Bender.yml ====
package:
  name: cdrx

sources:
  - source/cdrx_pkg.sv
  - source/cdrx_if.sv
  - source/cdrx_sdpram.sv
  - source/cdrx_frame_ram.sv
  - source/cdrx_frame_writer.sv
  - source/cdrx_host_reader.sv
  - source/cdrx_ctrl_regs.sv
  - source/cdrx_top.sv
  - target: test
    files:
      - verification/cdrx_tb.sv

// ==== verification/cdrx_tb.sv ====
// ============================================================
// receive controller testbench: clock, reset, timeout,
// directed tests and a queue model of the frame ring
// ============================================================
`timescale 1ns/1ps

module cdrx_tb import cdrx_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 20000;

    logic        clk;
    logic        reset_n;
    logic [7:0]  rx_byte;
    logic        rx_valid;
    logic        rx_end;
    logic        rx_crc_err;
    logic        host_req;
    host_op_e    host_op;
    logic [5:0]  host_word_idx;
    logic        host_ack;
    logic [31:0] host_rdata;
    logic        frame_ready;
    logic [7:0]  frame_len;
    logic        frame_err;
    logic        reg_req;
    logic        reg_write;
    reg_addr_e   reg_addr;
    logic [7:0]  reg_wdata;
    logic        reg_ack;
    logic [7:0]  reg_rdata;

    integer seed;
    int     errors = 0;
    int     test_errors;
    int     pass_count = 0;
    int     fail_count = 0;
    int     cycles = 0;

    // expected ring contents
    logic [7:0]         exp_bytes [$];             // stored frames back to back
    int                 exp_len [$];
    logic               exp_err [$];
    logic [I_WIDTH-1:0] m_wr_sel;
    logic [I_WIDTH-1:0] m_rd_sel;
    logic [BLOCKS-1:0]  m_dirty;
    int                 m_drops;
    logic               m_enable;
    logic [7:0]         frame_buf [0:299];

    cdrx_top uut (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic value_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic flag_failure(input string msg);
        $display("failure at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic begin_test();
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            pass_count++;
            $display("[%0t] %s: ok", $time, name);
        end else begin
            fail_count++;
            $display("[%0t] %s: %0d errors", $time, name, errors - test_errors);
        end
    endtask

    // a frame lands only if none of its blocks holds an unreleased frame
    task automatic store_expected(input int n, input logic crc);
        int                 stored;
        int                 nblk;
        int                 b;
        logic               hit;
        logic [I_WIDTH-1:0] blk;
        if (n > 0 && m_enable) begin
            stored = (n > MAX_FRAME) ? MAX_FRAME : n;
            nblk   = (stored + (1 << S_WIDTH) - 1) >> S_WIDTH;
            hit    = 1'b0;
            for (b = 0; b < nblk; b++) begin
                blk = m_wr_sel + I_WIDTH'(b);
                hit = hit | m_dirty[blk];
            end
            if (hit) begin
                if (m_drops < 255) begin
                    m_drops++;
                end
            end else begin
                for (b = 0; b < stored; b++) begin
                    exp_bytes.push_back(frame_buf[b]);
                end
                exp_len.push_back(stored);
                exp_err.push_back(crc || (n > MAX_FRAME));
                m_dirty[m_wr_sel] = 1'b1;
                m_wr_sel = m_wr_sel + I_WIDTH'(nblk);
            end
        end
    endtask

    task automatic retire_expected();
        int n;
        int b;
        if (exp_len.size() > 0) begin
            n = exp_len.pop_front();
            void'(exp_err.pop_front());
            for (b = 0; b < n; b++) begin
                void'(exp_bytes.pop_front());
            end
            m_dirty[m_rd_sel] = 1'b0;
            m_rd_sel = m_rd_sel + I_WIDTH'((n + (1 << S_WIDTH) - 1) >> S_WIDTH);
        end
    endtask

    task automatic clear_expected();
        exp_bytes.delete();
        exp_len.delete();
        exp_err.delete();
        m_wr_sel = '0;
        m_rd_sel = '0;
        m_dirty  = '0;
    endtask

    task automatic send_frame(input int n, input logic crc);
        int i;
        for (i = 0; i < n; i++) begin
            frame_buf[i] = 8'($random(seed));
        end
        store_expected(n, crc);
        for (i = 0; i < n; i++) begin
            @(posedge clk);
            rx_byte    <= frame_buf[i];
            rx_valid   <= 1'b1;
            rx_end     <= (i == n - 1);            // end marked with the last byte
            rx_crc_err <= crc;
        end
        @(posedge clk);
        rx_valid   <= 1'b0;
        rx_end     <= 1'b0;
        rx_crc_err <= 1'b0;
        repeat (3) @(posedge clk);                 // inter-frame gap
    endtask

    task automatic host_access(input host_op_e op, input logic [5:0] idx,
                               output logic [31:0] rdata);
        @(posedge clk);
        host_op       <= op;
        host_word_idx <= idx;
        host_req      <= 1'b1;
        @(posedge clk);
        while (!host_ack) @(posedge clk);
        rdata = host_rdata;
        host_req <= 1'b0;
        @(posedge clk);
        while (host_ack) @(posedge clk);
    endtask

    task automatic reg_access(input logic write, input reg_addr_e addr,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        @(posedge clk);
        reg_write <= write;
        reg_addr  <= addr;
        reg_wdata <= wdata;
        reg_req   <= 1'b1;
        @(posedge clk);
        while (!reg_ack) @(posedge clk);
        rdata = reg_rdata;
        reg_req <= 1'b0;
        @(posedge clk);
        while (reg_ack) @(posedge clk);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!frame_ready && n < 16) begin
            @(posedge clk);
            n++;
        end
        if (!frame_ready) begin
            flag_failure("frame_ready did not rise for a stored frame");
        end
    endtask

    task automatic check_ready();
        if (frame_ready !== (exp_len.size() > 0)) begin
            value_error($sformatf("frame_ready is %b, expected %b",
                                  frame_ready, exp_len.size() > 0));
        end
    endtask

    // fetch every word of the head frame, then release it
    task automatic read_head_frame();
        int          n;
        int          nw;
        int          w;
        int          b;
        logic [31:0] exp_word;
        logic [31:0] got;
        wait_ready();
        if (exp_len.size() == 0) begin
            flag_failure("no frame expected at the head of the ring");
        end else begin
            n  = exp_len[0];
            nw = (n + 3) / 4;
            if (frame_len !== 8'(n - 1)) begin
                value_error($sformatf("frame_len %0d, expected %0d", frame_len, n - 1));
            end
            if (frame_err !== exp_err[0]) begin
                value_error($sformatf("frame_err %b, expected %b", frame_err, exp_err[0]));
            end
            for (w = 0; w < nw; w++) begin
                host_access(OP_FETCH, 6'(w), got);
                exp_word = '0;
                for (b = 0; b < 4; b++) begin
                    if (4 * w + b < n) begin
                        exp_word[8*b +: 8] = exp_bytes[4 * w + b];
                    end
                end
                if (got !== exp_word) begin
                    value_error($sformatf("word %0d is %h, expected %h", w, got, exp_word));
                end
            end
            host_access(OP_RELEASE, 6'd0, got);
            retire_expected();
        end
    endtask

    task automatic single_frame();
        logic [31:0] got;
        begin_test();
        send_frame(37, 1'b0);
        read_head_frame();
        check_ready();
        host_access(OP_RELEASE, 6'd0, got);        // empty ring, ack only
        check_ready();
        end_test("single frame");
    endtask

    task automatic mixed_frames();
        int k;
        begin_test();
        send_frame(1, 1'b0);
        send_frame(32, 1'b0);
        send_frame(33, 1'b1);
        send_frame(256, 1'b0);
        for (k = 0; k < 4; k++) begin
            read_head_frame();
        end
        check_ready();
        end_test("mixed frames");
    endtask

    task automatic ring_overflow();
        logic [7:0] rdata;
        int         k;
        begin_test();
        for (k = 0; k < 8; k++) begin
            send_frame(MAX_FRAME, 1'b0);
        end
        send_frame(16, 1'b0);                      // ring is full
        reg_access(1'b0, REG_DROPS, 8'd0, rdata);
        if (rdata !== 8'(m_drops)) begin
            value_error($sformatf("REG_DROPS %0d, expected %0d", rdata, m_drops));
        end
        for (k = 0; k < 8; k++) begin
            read_head_frame();
        end
        send_frame(20, 1'b0);
        read_head_frame();
        end_test("ring overflow");
    endtask

    task automatic overlong_frame();
        begin_test();
        send_frame(300, 1'b0);
        read_head_frame();
        end_test("overlong frame");
    endtask

    task automatic register_control();
        logic [7:0] rdata;
        begin_test();
        reg_access(1'b1, REG_CTRL, 8'h00, rdata);
        m_enable = 1'b0;
        reg_access(1'b0, REG_CTRL, 8'h00, rdata);
        if (rdata !== 8'h00) begin
            value_error($sformatf("REG_CTRL %h, expected 00", rdata));
        end
        send_frame(20, 1'b0);
        repeat (8) @(posedge clk);
        check_ready();
        reg_access(1'b1, REG_CTRL, 8'h01, rdata);
        m_enable = 1'b1;
        reg_access(1'b0, REG_STATUS, 8'h00, rdata);
        if (rdata !== 8'(exp_len.size() > 0)) begin
            value_error($sformatf("REG_STATUS %h with an empty ring", rdata));
        end
        send_frame(40, 1'b0);
        send_frame(10, 1'b1);
        wait_ready();
        reg_access(1'b0, REG_STATUS, 8'h00, rdata);
        if (rdata !== 8'(exp_len.size() > 0)) begin
            value_error($sformatf("REG_STATUS %h with frames stored", rdata));
        end
        reg_access(1'b1, REG_CTRL, 8'h03, rdata);  // enable plus flush
        clear_expected();
        check_ready();
        reg_access(1'b0, REG_CTRL, 8'h00, rdata);
        if (rdata !== 8'h01) begin
            value_error($sformatf("REG_CTRL %h after flush, expected 01", rdata));
        end
        send_frame(12, 1'b0);
        read_head_frame();
        reg_access(1'b1, REG_DROPS, 8'h00, rdata);
        m_drops = 0;
        reg_access(1'b0, REG_DROPS, 8'h00, rdata);
        if (rdata !== 8'(m_drops)) begin
            value_error($sformatf("REG_DROPS %0d after clear, expected 0", rdata));
        end
        end_test("register control");
    endtask

    initial begin
        seed          = 15112;
        clk           = 1'b0;
        reset_n       = 1'b0;
        rx_byte       = 8'd0;
        rx_valid      = 1'b0;
        rx_end        = 1'b0;
        rx_crc_err    = 1'b0;
        host_req      = 1'b0;
        host_op       = OP_FETCH;
        host_word_idx = 6'd0;
        reg_req       = 1'b0;
        reg_write     = 1'b0;
        reg_addr      = REG_CTRL;
        reg_wdata     = 8'd0;
        m_drops       = 0;
        m_enable      = 1'b1;
        clear_expected();

        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        repeat (2) @(posedge clk);

        single_frame();
        mixed_frames();
        ring_overflow();
        overlong_frame();
        register_control();

        $display("tests finished: %0d ok, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== source/cdrx_top.sv ====
// ============================================================
// receive controller top: frame writer, frame RAM,
// host reader and control registers
// ============================================================
`timescale 1ns/1ps

module cdrx_top import cdrx_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,

    input  logic [7:0]  rx_byte,
    input  logic        rx_valid,
    input  logic        rx_end,
    input  logic        rx_crc_err,

    input  logic        host_req,
    input  host_op_e    host_op,
    input  logic [5:0]  host_word_idx,
    output logic        host_ack,
    output logic [31:0] host_rdata,

    output logic        frame_ready,
    output logic [7:0]  frame_len,
    output logic        frame_err,

    input  logic        reg_req,
    input  logic        reg_write,
    input  reg_addr_e   reg_addr,
    input  logic [7:0]  reg_wdata,
    output logic        reg_ack,
    output logic [7:0]  reg_rdata
);

    cdrx_wr_if wr_bus ();
    cdrx_rd_if rd_bus ();

    logic switch_fail;
    logic flush;
    logic rx_enable;

    // head frame status
    assign frame_ready = rd_bus.unread;
    assign frame_len   = rd_bus.rd_len;
    assign frame_err   = rd_bus.rd_err;

    cdrx_frame_writer u_writer (
        .clk        (clk),
        .reset_n    (reset_n),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid),
        .rx_end     (rx_end),
        .rx_crc_err (rx_crc_err),
        .rx_enable  (rx_enable),
        .wr         (wr_bus.writer)
    );

    cdrx_frame_ram u_ram (
        .clk         (clk),
        .reset_n     (reset_n),
        .wr          (wr_bus.ram),
        .rd          (rd_bus.ram),
        .flush       (flush),
        .switch_fail (switch_fail)
    );

    cdrx_host_reader u_reader (
        .clk           (clk),
        .reset_n       (reset_n),
        .host_req      (host_req),
        .host_op       (host_op),
        .host_word_idx (host_word_idx),
        .host_ack      (host_ack),
        .host_rdata    (host_rdata),
        .rd            (rd_bus.reader)
    );

    cdrx_ctrl_regs u_regs (
        .clk         (clk),
        .reset_n     (reset_n),
        .reg_req     (reg_req),
        .reg_write   (reg_write),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_ack     (reg_ack),
        .reg_rdata   (reg_rdata),
        .switch_fail (switch_fail),
        .frame_ready (frame_ready),
        .rx_enable   (rx_enable),
        .flush       (flush)
    );

endmodule

// ==== source/cdrx_ctrl_regs.sv ====
// ============================================================
// control registers: rx enable, flush pulse, drop counter,
// four-phase register access
// ============================================================
`timescale 1ns/1ps

module cdrx_ctrl_regs import cdrx_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       reg_req,
    input  logic       reg_write,
    input  reg_addr_e  reg_addr,
    input  logic [7:0] reg_wdata,
    output logic       reg_ack,
    output logic [7:0] reg_rdata,
    input  logic       switch_fail,
    input  logic       frame_ready,
    output logic       rx_enable,
    output logic       flush
);

    logic       req_meta;
    logic       req_s;
    logic [7:0] drops;
    logic       access;

    assign access = req_s && !reg_ack;             // one access per request

    always_ff @(posedge clk) begin
        if (access && !reg_write) begin
            case (reg_addr)
                REG_CTRL:   reg_rdata <= {7'd0, rx_enable};  // flush bit reads 0
                REG_STATUS: reg_rdata <= {7'd0, frame_ready};
                REG_DROPS:  reg_rdata <= drops;
                default:    reg_rdata <= 8'd0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            req_meta  <= 1'b0;
            req_s     <= 1'b0;
            reg_ack   <= 1'b0;
            rx_enable <= 1'b1;
            flush     <= 1'b0;
            drops     <= '0;
        end else begin
            req_meta <= reg_req;
            req_s    <= req_meta;
            flush    <= 1'b0;
            if (switch_fail && drops != 8'hff) begin
                drops <= drops + 8'd1;             // saturates at 255
            end
            if (access) begin
                reg_ack <= 1'b1;
                if (reg_write) begin
                    case (reg_addr)
                        REG_CTRL: begin
                            rx_enable <= reg_wdata[0];
                            flush     <= reg_wdata[1];
                        end
                        REG_DROPS: drops <= '0;
                        default:   ;
                    endcase
                end
            end else if (!req_s && reg_ack) begin
                reg_ack <= 1'b0;
            end
        end
    end

endmodule

// ==== source/cdrx_host_reader.sv ====
// ============================================================
// host reader: four-phase fetch and release requests
// served on the frame RAM read port
// ============================================================
`timescale 1ns/1ps

module cdrx_host_reader import cdrx_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        host_req,
    input  host_op_e    host_op,
    input  logic [5:0]  host_word_idx,
    output logic        host_ack,
    output logic [31:0] host_rdata,
    cdrx_rd_if.reader   rd
);

    reader_state_e state;
    logic          req_meta;
    logic          req_s;

    // fetch address and read data
    always_ff @(posedge clk) begin
        if (state == R_IDLE && req_s && host_op == OP_FETCH) begin
            rd.rd_addr <= host_word_idx;
        end
        if (state == R_ACK && host_op == OP_FETCH) begin
            host_rdata <= rd.rd_word;              // valid one cycle after rd_en
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            req_meta   <= 1'b0;
            req_s      <= 1'b0;
            state      <= R_IDLE;
            host_ack   <= 1'b0;
            rd.rd_en   <= 1'b0;
            rd.rd_done <= 1'b0;
        end else begin
            req_meta   <= host_req;
            req_s      <= req_meta;
            rd.rd_en   <= 1'b0;
            rd.rd_done <= 1'b0;
            case (state)
                R_IDLE: begin
                    if (req_s) begin
                        if (host_op == OP_FETCH) begin
                            rd.rd_en <= 1'b1;
                            state    <= R_READ;
                        end else begin
                            rd.rd_done <= 1'b1;    // ignored by the RAM when empty
                            state      <= R_ACK;
                        end
                    end
                end
                R_READ: state <= R_ACK;
                R_ACK: begin
                    host_ack <= 1'b1;
                    state    <= R_WAIT;
                end
                R_WAIT: begin
                    if (!req_s) begin
                        host_ack <= 1'b0;
                        state    <= R_IDLE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

endmodule

// ==== source/cdrx_frame_writer.sv ====
// ============================================================
// frame writer: byte stream to frame RAM write port,
// length tracking and overlong truncation
// ============================================================
`timescale 1ns/1ps

module cdrx_frame_writer import cdrx_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic [7:0] rx_byte,
    input  logic       rx_valid,
    input  logic       rx_end,
    input  logic       rx_crc_err,
    input  logic       rx_enable,
    cdrx_wr_if.writer  wr
);

    writer_state_e state;
    logic [8:0]    cnt;                            // bytes stored so far
    logic          crc_err_q;
    logic          overlong;

    logic          take;
    logic [8:0]    base;

    // the commit cycle takes no byte, the bus idles between frames
    assign take = rx_valid && rx_enable && (state != W_COMMIT);
    assign base = (state == W_IDLE) ? 9'd0 : cnt;

    assign wr.wr_len = 8'(cnt - 9'd1);             // held until the next frame starts
    assign wr.wr_err = crc_err_q | overlong;

    always_ff @(posedge clk) begin
        if (take) begin
            wr.wr_byte <= rx_byte;
            wr.wr_addr <= base[7:0];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= W_IDLE;
            cnt       <= '0;
            crc_err_q <= 1'b0;
            overlong  <= 1'b0;
            wr.wr_en  <= 1'b0;
            wr.switch <= 1'b0;
        end else begin
            wr.wr_en  <= 1'b0;
            wr.switch <= 1'b0;
            case (state)
                W_IDLE, W_RECV: begin
                    if (take) begin
                        if (state == W_IDLE) begin
                            overlong <= 1'b0;
                        end
                        if (base < MAX_FRAME) begin
                            wr.wr_en <= 1'b1;
                            cnt      <= base + 9'd1;
                        end else begin
                            overlong <= 1'b1;  // extra bytes discarded
                        end
                    end
                    if (rx_end && (state == W_RECV || take)) begin
                        wr.switch <= 1'b1;
                        crc_err_q <= rx_crc_err;
                        state     <= W_COMMIT;
                    end else if (take) begin
                        state <= W_RECV;
                    end
                end
                W_COMMIT: state <= W_IDLE;
                default:  state <= W_IDLE;
            endcase
        end
    end

endmodule

// ==== source/cdrx_frame_ram.sv ====
// ============================================================
// frame RAM: ring of 32-byte blocks with an index table,
// dirty bits, write cancel, frame switch and frame release
// ============================================================
`timescale 1ns/1ps

module cdrx_frame_ram import cdrx_pkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    cdrx_wr_if.ram wr,
    cdrx_rd_if.ram rd,
    input  logic  flush,                           // release all frames
    output logic  switch_fail
);

    typedef struct packed {
        logic               err;
        logic [F_WIDTH-1:0] extra;                 // blocks beyond the first
        logic [7:0]         len;
    } idx_entry_t;

    idx_entry_t idx_table [BLOCKS];
    idx_entry_t idx_rd_val;

    logic [I_WIDTH-1:0] wr_sel;
    logic [I_WIDTH-1:0] rd_sel;
    logic [BLOCKS-1:0]  dirty;

    logic               wr_cancel;
    logic               wr_en_d;
    logic               switch_d;
    logic [F_WIDTH-1:0] wr_extra;
    logic [31:0]        wr_word;
    logic [A_WIDTH-1:0] buf_wr_addr;

    logic [I_WIDTH-1:0] wr_blk;
    logic [I_WIDTH-1:0] rd_blk;
    logic [A_WIDTH-1:0] buf_rd_addr;

    // block hit by the current byte and by the current read
    assign wr_blk = wr_sel + I_WIDTH'(wr.wr_addr[7:S_WIDTH]);
    assign rd_blk = rd_sel + I_WIDTH'(rd.rd_addr[5:S_WIDTH-2]);
    assign buf_rd_addr = {rd_blk, rd.rd_addr[S_WIDTH-3:0]};

    assign rd.rd_len = idx_rd_val.len;
    assign rd.rd_err = idx_rd_val.err;

    cdrx_sdpram u_buf (
        .clk (clk),
        .cen (~rd.rd_en),
        .ra  (buf_rd_addr),
        .rd  (rd.rd_word),
        .wa  (buf_wr_addr),
        .wd  (wr_word),
        .wen (~wr_en_d)
    );

    // byte lanes, little-endian; lane 0 starts a fresh word
    always_ff @(posedge clk) begin
        if (wr.wr_en) begin
            buf_wr_addr <= {wr_blk, wr.wr_addr[S_WIDTH-1:2]};
            case (wr.wr_addr[1:0])
                2'd0:    wr_word <= {24'd0, wr.wr_byte};
                2'd1:    wr_word[15:8] <= wr.wr_byte;
                2'd2:    wr_word[23:16] <= wr.wr_byte;
                default: wr_word[31:24] <= wr.wr_byte;
            endcase
        end
    end

    // index table, written on a good switch
    always_ff @(posedge clk) begin
        idx_rd_val <= idx_table[rd_sel];
        if (switch_d && !wr_cancel) begin
            idx_table[wr_sel] <= '{err: wr.wr_err, extra: wr_extra, len: wr.wr_len};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_sel      <= '0;
            rd_sel      <= '0;
            dirty       <= '0;
            wr_cancel   <= 1'b0;
            wr_en_d     <= 1'b0;
            switch_d    <= 1'b0;
            wr_extra    <= '0;
            switch_fail <= 1'b0;
            rd.unread   <= 1'b0;
        end else begin
            switch_fail <= 1'b0;
            wr_en_d     <= 1'b0;
            switch_d    <= wr.switch;
            rd.unread   <= dirty[rd_sel];          // aligned with idx_rd_val

            if (wr.wr_en && !wr_cancel) begin
                if (dirty[wr_blk]) begin
                    wr_cancel <= 1'b1;             // block not yet released
                end else begin
                    wr_en_d  <= 1'b1;
                    wr_extra <= wr.wr_addr[7:S_WIDTH];
                end
            end

            if (switch_d) begin
                if (wr_cancel) begin
                    switch_fail <= 1'b1;
                end else begin
                    dirty[wr_sel] <= 1'b1;         // first block marks the frame
                    wr_sel <= wr_sel + I_WIDTH'(wr_extra) + 1'b1;
                end
                wr_cancel <= 1'b0;
            end

            if (rd.rd_done && dirty[rd_sel]) begin
                dirty[rd_sel] <= 1'b0;
                rd_sel <= rd_sel + I_WIDTH'(idx_rd_val.extra) + 1'b1;
            end

            if (flush) begin
                wr_sel      <= '0;
                rd_sel      <= '0;
                dirty       <= '0;
                wr_cancel   <= 1'b0;
                switch_d    <= 1'b0;
                switch_fail <= 1'b0;
            end
        end
    end

endmodule

// ==== source/cdrx_sdpram.sv ====
// ============================================================
// simple dual-port word RAM, registered read,
// active-low read and write enables
// ============================================================
`timescale 1ns/1ps

module cdrx_sdpram import cdrx_pkg::*; (
    input  logic               clk,
    input  logic               cen,                // low: read ra this cycle
    input  logic [A_WIDTH-1:0] ra,
    output logic [31:0]        rd,
    input  logic [A_WIDTH-1:0] wa,
    input  logic [31:0]        wd,
    input  logic               wen                 // low: write wd to wa
);

    logic [31:0] mem [1 << A_WIDTH];

    always_ff @(posedge clk) begin
        if (!wen) begin
            mem[wa] <= wd;
        end
        if (!cen) begin
            rd <= mem[ra];                         // output held otherwise
        end
    end

endmodule

// ==== source/cdrx_if.sv ====
// ============================================================
// cdrx_wr_if: frame RAM write port
// cdrx_rd_if: frame RAM read port
// ============================================================
`timescale 1ns/1ps

interface cdrx_wr_if;
    logic [7:0] wr_byte;
    logic [7:0] wr_addr;                           // byte offset within the frame
    logic       wr_en;
    logic       wr_err;
    logic [7:0] wr_len;                            // frame length minus one
    logic       switch;                            // commit pulse

    modport writer (output wr_byte, wr_addr, wr_en, wr_err, wr_len, switch);
    modport ram    (input  wr_byte, wr_addr, wr_en, wr_err, wr_len, switch);
endinterface

interface cdrx_rd_if;
    logic [5:0]  rd_addr;                          // word index within the frame
    logic        rd_en;
    logic        rd_done;                          // release the head frame
    logic [31:0] rd_word;
    logic        unread;
    logic [7:0]  rd_len;
    logic        rd_err;

    modport reader (output rd_addr, rd_en, rd_done, input rd_word, unread, rd_len, rd_err);
    modport ram    (input rd_addr, rd_en, rd_done, output rd_word, unread, rd_len, rd_err);
endinterface

// ==== source/cdrx_pkg.sv ====
// ============================================================
// receive controller package: buffer geometry, host opcodes,
// register addresses and the FSM state encodings
// ============================================================

package cdrx_pkg;

    // buffer geometry
    localparam int I_WIDTH   = 6;                  // index width, 64 blocks
    localparam int B_WIDTH   = 11;                 // byte address width, 2048 bytes
    localparam int S_WIDTH   = 5;                  // block byte width, 32 bytes
    localparam int F_WIDTH   = 3;                  // extra-block count width
    localparam int MAX_FRAME = 256;                // longest frame in bytes
    localparam int A_WIDTH   = B_WIDTH - 2;        // word address of the buffer
    localparam int BLOCKS    = 1 << I_WIDTH;       // blocks in the ring

    // host request opcodes
    typedef enum logic {
        OP_FETCH   = 1'b0,
        OP_RELEASE = 1'b1
    } host_op_e;

    // register map
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_STATUS = 2'd1,
        REG_DROPS  = 2'd2
    } reg_addr_e;

    // frame writer FSM
    typedef enum logic [1:0] {
        W_IDLE,
        W_RECV,
        W_COMMIT
    } writer_state_e;

    // host reader FSM
    typedef enum logic [1:0] {
        R_IDLE,
        R_READ,
        R_ACK,
        R_WAIT
    } reader_state_e;

endpackage
